/* common/addr_config.svh */
// Widths and sizes of the operand address stage, included by the package and every RTL module
`ifndef ADDR_CONFIG_SVH
`define ADDR_CONFIG_SVH

`define ADDR_W    24  // effective address width
`define REG_W     32  // one long register
`define REG_CNT   8   // XWA .. XSP
`define WIN_DEPTH 8   // instruction byte queue entries
`define WIN_AW    3   // queue pointer width, log2 of depth

`endif

/* common/addr_pkg.sv */
// Types shared by the window, index decoder and register bank of the address stage
`include "addr_config.svh"

package addr_pkg;

    // long register codes as found in the operand bytes
    typedef enum logic [$clog2(`REG_CNT)-1:0] {
        XWA, XBC, XDE, XHL, XIX, XIY, XIZ, XSP
    } reg_code_e;

    typedef enum logic [3:0] {
        REG_IND, REG_D8,            // (r32) and (r32+d8)
        ABS8, ABS16, ABS24,         // (#8) (#16) (#24)
        REG_IDX, REG_D16,           // indexed forms
        REG_R8, REG_R16,
        PRE_DEC, POST_INC           // (-r32) and (r32+)
    } addr_mode_e;

    typedef enum logic [1:0] {
        IDLE, PHASE2, CALC
    } dec_state_e;

    typedef struct packed {
        logic [7:0] b3;
        logic [7:0] b2;
        logic [7:0] b1;
        logic [7:0] b0;             // oldest byte
        logic [2:0] cnt;            // valid head bytes, saturates at 4
    } op_win_t;

    typedef struct packed {
        reg_code_e base;
        reg_code_e aux;
        logic      aux_w16;         // 1 reads low 16 bits of aux, 0 the low byte
    } reg_rd_t;

    typedef struct packed {
        logic      pulse;
        reg_code_e sel;
        logic      dec;             // 1 decrement, 0 increment
        logic [1:0] step;           // 0:1 1:2 2:4
    } reg_upd_t;

    function automatic logic [2:0] step_bytes(input logic [1:0] code);
        case (code)
            2'd0:    step_bytes = 3'd1;
            2'd1:    step_bytes = 3'd2;
            default: step_bytes = 3'd4;
        endcase
    endfunction

endpackage

/* design/op_window.sv */
// Eight-byte instruction queue feeding the head four bytes to the decoder and popping on consume
`timescale 1ns/100ps
`include "addr_config.svh"

module op_window (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_valid,
    input  logic [7:0]          load_byte,
    input  logic                consume,
    input  logic [2:0]          consume_cnt,
    output addr_pkg::op_win_t   win,
    output logic [`WIN_AW:0]    count
);
    import addr_pkg::*;

    logic [7:0]         mem [`WIN_DEPTH];
    logic [`WIN_AW-1:0] rd_ptr;
    logic [`WIN_AW-1:0] wr_ptr;
    logic [`WIN_AW-1:0] head1;
    logic [`WIN_AW-1:0] head2;
    logic [`WIN_AW-1:0] head3;
    logic               push;
    logic [2:0]         pop_n;

    assign push  = load_valid && (count != (`WIN_AW+1)'(`WIN_DEPTH)); // full drops the byte
    assign pop_n = consume ? consume_cnt : 3'd0;

    assign head1 = rd_ptr + `WIN_AW'(1);
    assign head2 = rd_ptr + `WIN_AW'(2);
    assign head3 = rd_ptr + `WIN_AW'(3);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= load_byte;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + `WIN_AW'(1);
            end
            rd_ptr <= rd_ptr + `WIN_AW'(pop_n);     // wraps with the buffer
            count  <= count + {{`WIN_AW{1'b0}}, push} - (`WIN_AW+1)'(pop_n);
        end
    end

    always_comb begin
        win.b0  = mem[rd_ptr];
        win.b1  = mem[head1];
        win.b2  = mem[head2];
        win.b3  = mem[head3];
        win.cnt = (count > (`WIN_AW+1)'(4)) ? 3'd4 : count[2:0];
    end

    // decoder must never ask for bytes that are not there yet
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        consume |-> ((`WIN_AW+1)'(consume_cnt) <= count));

    // no back-pressure, so a push into a full queue is lost
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        load_valid |-> (count != (`WIN_AW+1)'(`WIN_DEPTH)));

endmodule

/* idxaddr/idx_decoder.sv */
// Index addressing mode decoder computing the 24-bit effective address from the window head
`timescale 1ns/100ps
`include "addr_config.svh"

module idx_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  addr_pkg::op_win_t   win,
    input  logic [`REG_W-1:0]   base_data,
    input  logic [`REG_W-1:0]   aux_data,
    output addr_pkg::reg_rd_t   rd,
    output addr_pkg::reg_upd_t  upd,
    output logic                consume,
    output logic [2:0]          consume_cnt,
    output logic                busy,
    output logic                done,
    output logic [`ADDR_W-1:0]  addr
);
    import addr_pkg::*;

    dec_state_e         state_q;
    addr_mode_e         mode_q;
    reg_code_e          base_q;
    logic [`ADDR_W-1:0] off_q;
    logic [2:0]         cnt_q;
    logic [1:0]         step_q;

    // decode of the window head, only taken when start is high
    addr_mode_e         dec_mode;
    reg_code_e          dec_base;
    logic [`ADDR_W-1:0] dec_off;
    logic [2:0]         dec_cnt;
    logic [1:0]         dec_step;
    logic               dec_two_phase;

    logic               rr_mode;
    logic               use_base;
    logic [`ADDR_W-1:0] pre_step;
    logic [`ADDR_W-1:0] base_eff;
    logic [`ADDR_W-1:0] addend;
    logic [`ADDR_W-1:0] addr_nx;

    always_comb begin
        dec_mode = REG_IND;
        dec_base = reg_code_e'(win.b0[2:0]);
        dec_off  = '0;
        dec_cnt  = 3'd1;
        dec_step = 2'd0;
        if (!win.b0[6]) begin
            if (win.b0[3]) begin                        // displacement byte follows
                dec_mode = REG_D8;
                dec_off  = {{(`ADDR_W-8){win.b1[7]}}, win.b1};
                dec_cnt  = 3'd2;
            end
        end else begin
            dec_base = reg_code_e'(win.b1[4:2]);
            dec_step = win.b1[1:0];
            dec_cnt  = 3'd2;
            case (win.b0[3:0])
                4'h0: begin
                    dec_mode = ABS8;
                    dec_off  = {{(`ADDR_W-8){1'b0}}, win.b1};
                end
                4'h1: begin
                    dec_mode = ABS16;
                    dec_off  = {{(`ADDR_W-16){1'b0}}, win.b2, win.b1};
                    dec_cnt  = 3'd3;
                end
                4'h2: begin
                    dec_mode = ABS24;
                    dec_off  = {win.b3, win.b2, win.b1};
                    dec_cnt  = 3'd4;
                end
                4'h3: begin
                    case (win.b1[1:0])
                        2'd1:    dec_mode = REG_D16;    // offset read in phase two
                        2'd3:    dec_mode = win.b1[5] ? REG_R16 : REG_R8;
                        default: dec_mode = REG_IDX;
                    endcase
                end
                4'h4: dec_mode = PRE_DEC;
                4'h5: dec_mode = POST_INC;
                default: begin                          // unused codes fall back to (r32)
                    dec_base = reg_code_e'(win.b0[2:0]);
                    dec_cnt  = 3'd1;
                end
            endcase
        end
    end

    assign dec_two_phase = dec_mode inside {REG_D16, REG_R8, REG_R16};

    assign rr_mode  = mode_q inside {REG_R8, REG_R16};
    assign use_base = !(mode_q inside {ABS8, ABS16, ABS24});

    // register pair bytes sit at the window head once phase two has popped
    always_comb begin
        rd.base    = (state_q == CALC && rr_mode) ? reg_code_e'(win.b0[2:0]) : base_q;
        rd.aux     = reg_code_e'(win.b1[2:0]);
        rd.aux_w16 = (mode_q == REG_R16);
    end

    always_comb begin
        pre_step = '0;
        if (mode_q == PRE_DEC) begin
            pre_step = {{(`ADDR_W-3){1'b0}}, step_bytes(step_q)};
        end
        base_eff = use_base ? (base_data[`ADDR_W-1:0] - pre_step) : '0;
        case (mode_q)
            REG_D16: addend = {{(`ADDR_W-16){win.b1[7]}}, win.b1, win.b0};
            REG_R8:  addend = {{(`ADDR_W-8){aux_data[7]}}, aux_data[7:0]};
            REG_R16: addend = {{(`ADDR_W-16){aux_data[15]}}, aux_data[15:0]};
            default: addend = off_q;
        endcase
        addr_nx = base_eff + addend;                    // wraps at 24 bits
    end

    assign busy        = (state_q != IDLE);
    assign consume     = busy;                          // 2 in phase two, the rest in CALC
    assign consume_cnt = cnt_q;

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start) begin
            base_q <= dec_base;
            off_q  <= dec_off;
            cnt_q  <= dec_cnt;
            step_q <= dec_step;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            mode_q  <= REG_IND;
            done    <= 1'b0;
            addr    <= '0;
            upd     <= '0;
        end else begin
            done      <= 1'b0;
            upd.pulse <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q <= dec_two_phase ? PHASE2 : CALC;
                        mode_q  <= dec_mode;
                    end
                end
                PHASE2: state_q <= CALC;
                CALC: begin
                    state_q   <= IDLE;
                    addr      <= addr_nx;
                    done      <= 1'b1;
                    upd.pulse <= mode_q inside {PRE_DEC, POST_INC};
                    upd.sel   <= base_q;
                    upd.dec   <= (mode_q == PRE_DEC);
                    upd.step  <= step_q;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // a request needs a whole instruction in the window and an idle decoder
    a_start_ok: assert property (@(posedge clk) disable iff (rst)
        start |-> (!busy && win.cnt == 3'd4));

endmodule

/* design/reg_bank.sv */
// Bank of the eight long registers with base and aux read ports, a load port and step updates
`timescale 1ns/100ps
`include "addr_config.svh"

module reg_bank (
    input  logic                clk,
    input  logic                rst,
    input  addr_pkg::reg_rd_t   rd,
    output logic [`REG_W-1:0]   base_data,
    output logic [`REG_W-1:0]   aux_data,
    input  addr_pkg::reg_upd_t  upd,
    input  logic                reg_wr,
    input  addr_pkg::reg_code_e reg_wr_sel,
    input  logic [`REG_W-1:0]   reg_wr_data
);
    import addr_pkg::*;

    logic [`REG_W-1:0] regs [`REG_CNT];
    logic [`REG_W-1:0] upd_cur;
    logic [`REG_W-1:0] upd_step;
    logic [`REG_W-1:0] upd_val;
    logic [`REG_W-1:0] aux_full;

    assign upd_cur  = regs[upd.sel];
    assign upd_step = {{(`REG_W-3){1'b0}}, step_bytes(upd.step)};
    assign upd_val  = upd.dec ? (upd_cur - upd_step) : (upd_cur + upd_step); // full 32 bits

    assign base_data = regs[rd.base];
    assign aux_full  = regs[rd.aux];

    // only the low half or low byte of the aux register takes part
    always_comb begin
        if (rd.aux_w16) begin
            aux_data = {{(`REG_W-16){1'b0}}, aux_full[15:0]};
        end else begin
            aux_data = {{(`REG_W-8){1'b0}}, aux_full[7:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_CNT; i++) begin
                if (reg_wr && reg_wr_sel == reg_code_e'(i)) begin
                    regs[i] <= reg_wr_data;                 // load wins over step
                end else if (upd.pulse && upd.sel == reg_code_e'(i)) begin
                    regs[i] <= upd_val;
                end
            end
        end
    end

endmodule

/* design/addr_unit_top.sv */
// Top of the operand address stage tying the byte window, index decoder and register bank together
`timescale 1ns/100ps
`include "addr_config.svh"

module addr_unit_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_valid,
    input  logic [7:0]          load_byte,
    input  logic                start,
    input  logic                reg_wr,
    input  addr_pkg::reg_code_e reg_wr_sel,
    input  logic [`REG_W-1:0]   reg_wr_data,
    output logic                busy,
    output logic                done,
    output logic [`ADDR_W-1:0]  addr,
    output logic [`WIN_AW:0]    win_count
);
    import addr_pkg::*;

    op_win_t           win;
    reg_rd_t           rd;
    reg_upd_t          upd;
    logic [`REG_W-1:0] base_data;
    logic [`REG_W-1:0] aux_data;
    logic              consume;
    logic [2:0]        consume_cnt;

    op_window u_op_window (
        .clk         (clk),
        .rst         (rst),
        .load_valid  (load_valid),
        .load_byte   (load_byte),
        .consume     (consume),
        .consume_cnt (consume_cnt),
        .win         (win),
        .count       (win_count)
    );

    idx_decoder u_idx_decoder (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .win         (win),
        .base_data   (base_data),
        .aux_data    (aux_data),
        .rd          (rd),
        .upd         (upd),
        .consume     (consume),
        .consume_cnt (consume_cnt),
        .busy        (busy),
        .done        (done),
        .addr        (addr)
    );

    reg_bank u_reg_bank (
        .clk         (clk),
        .rst         (rst),
        .rd          (rd),
        .base_data   (base_data),
        .aux_data    (aux_data),
        .upd         (upd),
        .reg_wr      (reg_wr),
        .reg_wr_sel  (reg_wr_sel),
        .reg_wr_data (reg_wr_data)
    );

endmodule

/* verification/clk_gen.sv */
// Testbench clock and reset source: 10 ns clock, reset held for the first 4 rising edges
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;  // released just after the 4th edge
    end

endmodule

/* verification/tb_addr_unit.sv */
// Directed testbench of the operand address stage, run from the top with list.f
`timescale 1ns/100ps
`include "addr_config.svh"

module tb_addr_unit;
    import addr_pkg::*;

    logic               clk;
    logic               rst;
    logic               load_valid;
    logic [7:0]         load_byte;
    logic               start;
    logic               reg_wr;
    reg_code_e          reg_wr_sel;
    logic [`REG_W-1:0]  reg_wr_data;
    logic               busy;
    logic               done;
    logic [`ADDR_W-1:0] addr;
    logic [`WIN_AW:0]   win_count;

    logic [31:0] reg_m [`REG_CNT];  // expected register contents
    logic [7:0]  win_q [$];         // expected window contents
    logic [7:0]  feed_q [$];        // bytes waiting to be pushed
    logic [31:0] lcg_state = 32'd71;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    addr_unit_top u_addr_unit_top (
        .clk(clk), .rst(rst), .load_valid(load_valid), .load_byte(load_byte),
        .start(start), .reg_wr(reg_wr), .reg_wr_sel(reg_wr_sel), .reg_wr_data(reg_wr_data),
        .busy(busy), .done(done), .addr(addr), .win_count(win_count)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [23:0] sext8(input logic [7:0] v);
        return {{16{v[7]}}, v};
    endfunction

    function automatic logic [23:0] sext16(input logic [15:0] v);
        return {{8{v[15]}}, v};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        load_valid = 1'b1;
        load_byte  = b;
        win_q.push_back(b);
        @(posedge clk);
        #1 load_valid = 1'b0;
    endtask

    task automatic load_reg(input int r, input logic [31:0] v);
        reg_wr      = 1'b1;
        reg_wr_sel  = reg_code_e'(r[2:0]);
        reg_wr_data = v;
        reg_m[r]    = v;
        @(posedge clk);
        #1 reg_wr = 1'b0;
    endtask

    task automatic feed_code(input logic [31:0] code, input int len);
        for (int i = 0; i < len; i++) begin
            feed_q.push_back(code[8*i +: 8]);
        end
    endtask

    // one start pulse on the current window head, refilling from feed_q while busy
    task automatic run_one(input logic [23:0] exp_addr, input int cnt, input int cyc_exp,
                           input string name);
        int cyc;
        while (win_q.size() < 4) begin
            push_byte((feed_q.size() > 0) ? feed_q.pop_front() : 8'h00); // 00 is (XWA)
        end
        check_value({name, " busy before start"}, 32'(busy), 32'd0);
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        cyc = 1;
        while (!done) begin
            if (cyc > 20) begin
                $display("done did not arrive within 20 cycles of start (%s)", name);
                $display("Checks failed");
                $fatal(1, "no done");
            end
            check_value({name, " busy"}, 32'(busy), 32'd1);
            load_valid = (feed_q.size() > 0) && (win_q.size() < `WIN_DEPTH);
            if (load_valid) begin
                load_byte = feed_q.pop_front();
                win_q.push_back(load_byte);
            end
            @(posedge clk);
            #1 cyc++;
        end
        load_valid = 1'b0;
        check_value({name, " addr"}, 32'(addr), 32'(exp_addr));
        check_value({name, " done latency"}, 32'(cyc), 32'(cyc_exp));
        repeat (cnt) void'(win_q.pop_front());
        check_value({name, " win_count"}, 32'(win_count), 32'(win_q.size()));
    endtask

    // pushes one instruction, then clears any padding ahead of it
    task automatic run_instr(input logic [31:0] code, input int len, input logic [23:0] exp_addr,
                             input int cnt, input int cyc_exp, input string name);
        int pads;
        pads = win_q.size();
        for (int i = 0; i < len; i++) begin
            push_byte(code[8*i +: 8]);
        end
        repeat (pads) run_one(reg_m[0][23:0], 1, 2, "pad");
        run_one(exp_addr, cnt, cyc_exp, name);
    endtask

    task automatic test_reg_indirect();
        logic [31:0] v;
        logic [7:0]  d;
        for (int r = 0; r < `REG_CNT; r++) begin
            v = lcg_next();
            d = lcg_next() >> 8;
            load_reg(r, v);
            run_instr({29'h0, r[2:0]}, 1, v[23:0], 1, 2, "reg_ind");
            run_instr({16'h0, d, 5'b00001, r[2:0]}, 2, v[23:0] + sext8(d), 2, 2, "reg_d8");
        end
    endtask

    task automatic test_absolute();
        logic [31:0] v;
        v = lcg_next();
        run_instr({16'h0, v[7:0], 8'h40}, 2, {16'h0, v[7:0]}, 2, 2, "abs8");
        run_instr({8'h0, v[23:8], 8'h41}, 3, {8'h0, v[23:8]}, 3, 2, "abs16");
        run_instr({v[31:8], 8'h42}, 4, v[31:8], 4, 2, "abs24");
    endtask

    task automatic test_indexed();
        logic [31:0] v;
        logic [2:0]  rb;
        logic [2:0]  ra;
        for (int n = 0; n < 4; n++) begin
            v  = lcg_next();
            rb = v[2:0];
            ra = v[6:4];
            load_reg(rb, lcg_next());
            load_reg(ra, lcg_next());
            run_instr({v[31:16], 3'b000, rb, 2'b01, 8'h43}, 4,
                      reg_m[rb][23:0] + sext16(v[31:16]), 4, 3, "d16");
            run_instr({5'h0, ra, 5'h0, rb, 8'h03, 8'h43}, 4,
                      reg_m[rb][23:0] + sext8(reg_m[ra][7:0]), 4, 3, "r_r8");
            run_instr({5'h0, ra, 5'h0, rb, 8'h23, 8'h43}, 4,
                      reg_m[rb][23:0] + sext16(reg_m[ra][15:0]), 4, 3, "r_r16");
        end
    endtask

    task automatic test_pre_post();
        logic [31:0] v;
        logic [2:0]  r;
        logic [31:0] step;
        for (int s = 0; s < 3; s++) begin
            step = 32'd1 << s;
            v = lcg_next();
            r = v[10:8];
            load_reg(r, v);
            run_instr({16'h0, 3'b000, r, s[1:0], 8'h44}, 2, v[23:0] - step[23:0], 2, 2, "pre_dec");
            reg_m[r] = v - step;
            run_instr({29'h0, r}, 1, reg_m[r][23:0], 1, 2, "after pre_dec");
            v = reg_m[r];
            run_instr({16'h0, 3'b000, r, s[1:0], 8'h45}, 2, v[23:0], 2, 2, "post_inc");
            reg_m[r] = v + step;
            run_instr({29'h0, r}, 1, reg_m[r][23:0], 1, 2, "after post_inc");
        end
    endtask

    task automatic test_back_to_back();
        logic [31:0] v;
        int pads;
        v = lcg_next();
        feed_code({16'h0, v[7:0], 8'h40}, 2);
        feed_code(32'h01, 1);
        feed_code({v[23:8], 8'h11, 8'h43}, 4);      // (XIX+d16)
        feed_code({16'h0, v[31:24], 8'h0b}, 2);     // (XHL+d8)
        feed_code({v[31:8], 8'h42}, 4);
        pads = win_q.size();
        while (win_q.size() < 4 + pads) begin
            push_byte(feed_q.pop_front());
        end
        repeat (pads) run_one(reg_m[0][23:0], 1, 2, "pad");
        run_one({16'h0, v[7:0]}, 2, 2, "b2b abs8");
        run_one(reg_m[1][23:0], 1, 2, "b2b reg_ind");
        run_one(reg_m[4][23:0] + sext16(v[23:8]), 4, 3, "b2b d16");
        run_one(reg_m[3][23:0] + sext8(v[31:24]), 2, 2, "b2b d8");
        run_one(v[31:8], 4, 2, "b2b abs24");
    endtask

    initial begin
        #20000;
        $display("Timeout: the tests did not finish within 20000 ns");
        $display("Checks failed");
        $fatal(1, "watchdog");
    end

    initial begin
        load_valid  = 1'b0;
        load_byte   = 8'h00;
        start       = 1'b0;
        reg_wr      = 1'b0;
        reg_wr_sel  = XWA;
        reg_wr_data = '0;
        for (int i = 0; i < `REG_CNT; i++) begin
            reg_m[i] = '0;
        end
        @(negedge rst);
        @(posedge clk);
        #1;
        test_reg_indirect();
        test_absolute();
        test_indexed();
        test_pre_post();
        test_back_to_back();
        $display("All checks passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/addr_pkg.sv
design/op_window.sv
idxaddr/idx_decoder.sv
design/reg_bank.sv
design/addr_unit_top.sv
verification/clk_gen.sv
verification/tb_addr_unit.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_addr_unit
FLIST = list.f
LOG   = sim.log

SRCS = $(shell grep -v '^+' $(FLIST)) common/addr_config.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
